/* Bender.yml */
package:
  name: line_store

sources:
  # Packages first, then RTL bottom up
  - files:
      - hdl/line_store_cfg_pkg.sv
      - hdl/line_store_msg_pkg.sv
      - hdl/sdp_ram.sv
      - hdl/hit_merge.sv
      - hdl/line_store_top.sv

  # Testbench, top module line_store_tb
  - target: test
    files:
      - tests/line_store_tb.sv

/* hdl/hit_merge.sv */
// Lookup tracker that aligns tag and data reads and forms the hit mask and masked data
module hit_merge #(
    parameter int PIPELINE_DEPTH = 1  // Must match the RAM output pipeline
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // Lookup issue side
    input  bit                               lu_valid,
    input  line_store_cfg_pkg::line_tag_t    lu_tag,
    // Aligned RAM read words
    input  line_store_msg_pkg::tag_entry_t   tag_rdata,
    input  line_store_cfg_pkg::line_data_t   data_rdata,
    // Response
    output bit                               rsp_valid,
    output line_store_msg_pkg::lookup_rsp_t  rsp
);

    import line_store_cfg_pkg::*;

    // Array register plus output stages
    localparam int LATENCY = 1 + PIPELINE_DEPTH;

    logic [LATENCY-1:0] valid_pipe;             // Lookup in flight per stage
    line_tag_t          tag_pipe [LATENCY];     // Tag riding alongside each read
    line_tag_t          tag_aligned;            // Tag of the lookup now at the RAM output
    logic               tag_match;
    col_mask_t          hit_mask;

    // Valid and tag delay line
    // Tag stages load only with their valid bit, same as the RAM stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_pipe <= '0;
            for (int s = 0; s < LATENCY; s++) begin
                tag_pipe[s] <= '0;
            end
        end else begin
            valid_pipe[0] <= lu_valid;
            if (lu_valid) begin
                tag_pipe[0] <= lu_tag;
            end
            for (int s = 1; s < LATENCY; s++) begin
                valid_pipe[s] <= valid_pipe[s-1];
                if (valid_pipe[s-1]) begin
                    tag_pipe[s] <= tag_pipe[s-1];
                end
            end
        end
    end

    assign tag_aligned = tag_pipe[LATENCY-1];

    // Hit test, no added cycle
    assign tag_match = (tag_rdata.tag == tag_aligned);
    assign hit_mask  = tag_match ? tag_rdata.valid_mask : '0;  // Valid bits only count on match

    // Response word
    always_comb begin
        rsp.hit_mask = hit_mask;
        for (int c = 0; c < NUM_COL; c++) begin
            // Miss columns read as zero
            rsp.data[c*COL_WIDTH +: COL_WIDTH] =
                hit_mask[c] ? data_rdata[c*COL_WIDTH +: COL_WIDTH] : '0;
        end
    end

    assign rsp_valid = valid_pipe[LATENCY-1];  // One strobe per lookup

    // Response word fully known on every strobe once out of reset
    a_rsp_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid |-> !$isunknown(rsp)
    ) else $error("Response unknown while rsp_valid is high");

    // A response whose stored tag differs from the tag issued LATENCY cycles ago must miss
    a_miss_on_tag_mismatch: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid && (tag_rdata.tag != $past(lu_tag, LATENCY)) |-> rsp.hit_mask == '0
    ) else $error("Hit reported on tag mismatch");

endmodule

/* hdl/line_store_cfg_pkg.sv */
// Line store geometry: index, tag and column widths with their vector types
package line_store_cfg_pkg;

    // Direct-mapped, one tag entry per line
    localparam int INDEX_WIDTH = 6;   // 64 lines
    localparam int TAG_WIDTH   = 10;  // Upper address bits kept per line

    // Data word split into independently writable columns
    localparam int NUM_COL     = 4;
    localparam int COL_WIDTH   = 16;
    localparam int DATA_WIDTH  = NUM_COL * COL_WIDTH;  // 64 bit line

    // Line index into both RAMs
    typedef logic [INDEX_WIDTH-1:0] line_index_t;

    // Stored and compared tag
    typedef logic [TAG_WIDTH-1:0] line_tag_t;

    // One bit per column
    // Used for write enables, valid bits and hit bits alike
    typedef logic [NUM_COL-1:0] col_mask_t;

    // Full line payload, column 0 in the low bits
    typedef logic [DATA_WIDTH-1:0] line_data_t;

endpackage

/* hdl/line_store_msg_pkg.sv */
// Line store request, response and tag entry formats
package line_store_msg_pkg;

    import line_store_cfg_pkg::*;

    // Write request
    // Data columns land where col_mask is set, the tag entry is replaced whole
    typedef struct packed {
        line_index_t index;     // Target line
        line_tag_t   tag;       // New tag for the line
        col_mask_t   col_mask;  // Columns written, also the new valid mask
        line_data_t  data;      // Full word, unmasked columns ignored
    } wr_req_t;

    // Lookup request
    typedef struct packed {
        line_index_t index;  // Line to read
        line_tag_t   tag;    // Tag to compare against
    } lookup_req_t;

    // Lookup response, one per lookup, in order
    typedef struct packed {
        col_mask_t  hit_mask;  // Tag match AND stored valid bits
        line_data_t data;      // Miss columns read as zero
    } lookup_rsp_t;

    // One word of the tag RAM
    // Valid mask zero after reset so every line misses
    typedef struct packed {
        line_tag_t tag;
        col_mask_t valid_mask;  // Columns holding live data
    } tag_entry_t;

endpackage

/* hdl/line_store_top.sv */
// Tagged line store top, splitting requests onto the tag and data RAMs and merging lookups
module line_store_top #(
    parameter int PIPELINE_DEPTH = 1,  // RAM output stages, latency is 1 + this
    parameter int CASCADE_DEPTH  = 4   // Block cascade limit for both RAMs
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // Write request strobe
    input  logic                             wr_valid,
    input  line_store_msg_pkg::wr_req_t      wr_req,
    // Lookup request strobe
    input  logic                             lu_valid,
    input  line_store_msg_pkg::lookup_req_t  lu_req,
    // Lookup response strobe
    output logic                             rsp_valid,
    output line_store_msg_pkg::lookup_rsp_t  rsp
);

    import line_store_cfg_pkg::*;
    import line_store_msg_pkg::*;

    localparam int TAG_ENTRY_WIDTH = $bits(tag_entry_t);

    tag_entry_t wr_entry;    // New tag word for the written line
    tag_entry_t tag_rdata;   // Tag word at the RAM output
    line_data_t data_rdata;  // Data word at the RAM output

    // Written columns become the valid mask, old valid bits dropped
    assign wr_entry.tag        = wr_req.tag;
    assign wr_entry.valid_mask = wr_req.col_mask;

    // Tag RAM, one full-width column
    sdp_ram #(
        .ADDR_WIDTH     (INDEX_WIDTH),
        .NUM_COL        (1),
        .COL_WIDTH      (TAG_ENTRY_WIDTH),
        .PIPELINE_DEPTH (PIPELINE_DEPTH),
        .CASCADE_DEPTH  (CASCADE_DEPTH)
    ) tag_ram0 (
        .clk     (clk),
        .a_en    (wr_valid),
        .a_wbe   (1'b1),          // Whole entry on every write
        .a_wdata (wr_entry),
        .a_addr  (wr_req.index),
        .b_en    (lu_valid),
        .b_addr  (lu_req.index),
        .b_rdata (tag_rdata)
    );

    // Data RAM, column enables from the write mask
    sdp_ram #(
        .ADDR_WIDTH     (INDEX_WIDTH),
        .NUM_COL        (NUM_COL),
        .COL_WIDTH      (COL_WIDTH),
        .PIPELINE_DEPTH (PIPELINE_DEPTH),
        .CASCADE_DEPTH  (CASCADE_DEPTH)
    ) data_ram0 (
        .clk     (clk),
        .a_en    (wr_valid),
        .a_wbe   (wr_req.col_mask),
        .a_wdata (wr_req.data),
        .a_addr  (wr_req.index),
        .b_en    (lu_valid),
        .b_addr  (lu_req.index),
        .b_rdata (data_rdata)
    );

    // Tag compare and column masking
    hit_merge #(
        .PIPELINE_DEPTH (PIPELINE_DEPTH)
    ) merge0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .lu_valid   (lu_valid),
        .lu_tag     (lu_req.tag),
        .tag_rdata  (tag_rdata),
        .data_rdata (data_rdata),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

    // No collision logic in the RAMs
    // Same-index write and lookup in one cycle would return undefined data
    a_no_rw_collision: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_valid && lu_valid |-> wr_req.index != lu_req.index
    ) else $error("Write and lookup to the same index in one cycle");

endmodule

/* hdl/sdp_ram.sv */
// Simple dual-port RAM with column write enables and enable-tracked read pipeline
module sdp_ram #(
    parameter int ADDR_WIDTH     = 6,
    parameter int NUM_COL        = 4,   // Independently writable columns
    parameter int COL_WIDTH      = 16,  // Bits per column
    parameter int PIPELINE_DEPTH = 1,   // Extra output register stages
    parameter int CASCADE_DEPTH  = 4    // Max block cascade, deeper is smaller but slower
) (
    input  logic                         clk,
    // Port A, write only
    input  logic                         a_en,
    input  logic [NUM_COL-1:0]           a_wbe,
    input  logic [NUM_COL*COL_WIDTH-1:0] a_wdata,
    input  logic [ADDR_WIDTH-1:0]        a_addr,
    // Port B, read only
    input  logic                         b_en,
    input  logic [ADDR_WIDTH-1:0]        b_addr,
    output logic [NUM_COL*COL_WIDTH-1:0] b_rdata
);

    localparam int DATA_WIDTH = NUM_COL * COL_WIDTH;
    localparam int DEPTH      = 1 << ADDR_WIDTH;

    (* cascade_height = CASCADE_DEPTH *)
    logic [DATA_WIDTH-1:0] mem [DEPTH];

    logic [DATA_WIDTH-1:0] b_ram_q;  // Raw array output register

    // Contents start cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Port A column writes
    always_ff @(posedge clk) begin
        for (int c = 0; c < NUM_COL; c++) begin
            if (a_en && a_wbe[c]) begin
                mem[a_addr][c*COL_WIDTH +: COL_WIDTH] <= a_wdata[c*COL_WIDTH +: COL_WIDTH];
            end
        end
    end

    // Port B array read, first cycle of latency
    always_ff @(posedge clk) begin
        if (b_en) begin
            b_ram_q <= mem[b_addr];
        end
    end

    generate
        if (PIPELINE_DEPTH > 0) begin : gen_out_pipe
            logic [DATA_WIDTH-1:0]     data_pipe [PIPELINE_DEPTH];
            logic [PIPELINE_DEPTH-1:0] en_pipe;  // Marks which stage receives a new word

            always_ff @(posedge clk) begin
                en_pipe[0] <= b_en;
                if (en_pipe[0]) begin
                    data_pipe[0] <= b_ram_q;
                end
                for (int s = 1; s < PIPELINE_DEPTH; s++) begin
                    en_pipe[s] <= en_pipe[s-1];
                    if (en_pipe[s]) begin  // Stage holds until its own word arrives
                        data_pipe[s] <= data_pipe[s-1];
                    end
                end
            end

            assign b_rdata = data_pipe[PIPELINE_DEPTH-1];
        end else begin : gen_out_direct
            assign b_rdata = b_ram_q;  // Single cycle read
        end
    endgenerate

endmodule

/* src.f */
hdl/line_store_cfg_pkg.sv
hdl/line_store_msg_pkg.sv
hdl/sdp_ram.sv
hdl/hit_merge.sv
hdl/line_store_top.sv
tests/line_store_tb.sv

/* tests/line_store_tb.sv */
// Line store testbench with reference model, response monitor and directed tests
module line_store_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import line_store_cfg_pkg::*;
    import line_store_msg_pkg::*;

    localparam int PIPELINE_DEPTH = 2;
    localparam int LATENCY        = 1 + PIPELINE_DEPTH;  // Edges from lookup to response
    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_LINES      = 1 << INDEX_WIDTH;
    localparam int STREAM_LEN     = 96;                  // Back-to-back lookups in test 5

    // Cycle budget per test, a drained access costs at most LATENCY + 3
    localparam int T1_CYCLES    = 4 * (LATENCY + 3) + 10;
    localparam int T2_CYCLES    = 2 * (LATENCY + 3);
    localparam int T3_CYCLES    = 2 * (LATENCY + 3);
    localparam int T4_CYCLES    = 5 * (LATENCY + 3);
    localparam int T5_CYCLES    = NUM_LINES + STREAM_LEN + 2 * (LATENCY + 3);
    localparam int TOTAL_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                  + T4_CYCLES + T5_CYCLES;
    localparam int MARGIN_CYCLES = 100;

    // Lookup awaiting its response
    typedef struct packed {
        int unsigned due;  // Cycle count at which rsp_valid must be seen
        lookup_rsp_t rsp;  // Expected response
    } pending_t;

    logic        clk;
    logic        rst_n;
    logic        wr_valid;
    wr_req_t     wr_req;
    logic        lu_valid;
    lookup_req_t lu_req;
    logic        rsp_valid;
    lookup_rsp_t rsp;

    // Reference model, one entry per line
    line_tag_t   model_tag   [NUM_LINES];
    col_mask_t   model_valid [NUM_LINES];
    line_data_t  model_data  [NUM_LINES];

    pending_t    pending_q [$];
    int unsigned cycle    = 0;  // Rising edges since start
    int unsigned last_due = 0;  // Due cycle of the newest lookup

    line_store_top #(
        .PIPELINE_DEPTH (PIPELINE_DEPTH),
        .CASCADE_DEPTH  (4)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_req    (wr_req),
        .lu_valid  (lu_valid),
        .lu_req    (lu_req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;  // Stable at every falling edge

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] observed);
        if (observed !== expected) begin
            $display("FAILED %s expected %h observed %h", name, expected, observed);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // Hit only where tag matches and column is valid, miss columns read zero
    function automatic lookup_rsp_t predict_rsp(input line_index_t index, input line_tag_t tag);
        lookup_rsp_t r;
        r.hit_mask = (model_tag[index] == tag) ? model_valid[index] : '0;
        for (int c = 0; c < NUM_COL; c++) begin
            r.data[c*COL_WIDTH +: COL_WIDTH] =
                r.hit_mask[c] ? model_data[index][c*COL_WIDTH +: COL_WIDTH] : '0;
        end
        return r;
    endfunction

    // Response monitor, order and edge of every strobe
    always @(negedge clk) begin
        pending_t head;
        if (rst_n) begin
            if (rsp_valid) begin
                if (pending_q.size() == 0) begin
                    report_failure("rsp_valid went high with no lookup in flight");
                end else begin
                    head = pending_q.pop_front();
                    if (head.due != cycle) begin
                        report_failure($sformatf("rsp_valid arrived at cycle %0d, expected at %0d",
                                                 cycle, head.due));
                    end
                    check_value("rsp.hit_mask", head.rsp.hit_mask, rsp.hit_mask);
                    check_value("rsp.data", head.rsp.data, rsp.data);
                end
            end else if (pending_q.size() != 0 && pending_q[0].due <= cycle) begin
                report_failure($sformatf("rsp_valid missing at cycle %0d for a pending lookup",
                                         cycle));
            end
        end
    end

    task automatic drive_write(input line_index_t index, input line_tag_t tag,
                               input col_mask_t mask, input line_data_t data);
        @(negedge clk);
        lu_valid        = 1'b0;
        wr_valid        = 1'b1;
        wr_req.index    = index;
        wr_req.tag      = tag;
        wr_req.col_mask = mask;
        wr_req.data     = data;
        // Tag and valid replaced, only masked columns of data change
        model_tag[index]   = tag;
        model_valid[index] = mask;
        for (int c = 0; c < NUM_COL; c++) begin
            if (mask[c]) begin
                model_data[index][c*COL_WIDTH +: COL_WIDTH] = data[c*COL_WIDTH +: COL_WIDTH];
            end
        end
    endtask

    task automatic drive_lookup(input line_index_t index, input line_tag_t tag);
        pending_t p;
        @(negedge clk);
        wr_valid     = 1'b0;
        lu_valid     = 1'b1;
        lu_req.index = index;
        lu_req.tag   = tag;
        p.due        = cycle + LATENCY;  // Captured at the next rising edge
        p.rsp        = predict_rsp(index, tag);
        last_due     = p.due;
        pending_q.push_back(p);
    endtask

    // Idle until every issued lookup has had its response edge
    task automatic drain_lookups();
        @(negedge clk);
        wr_valid = 1'b0;
        lu_valid = 1'b0;
        while (cycle <= last_due) @(negedge clk);
        if (pending_q.size() != 0) begin
            report_failure("lookups still pending after their response cycle");
        end
    endtask

    task automatic idle_for(input int n);
        @(negedge clk);
        wr_valid = 1'b0;
        lu_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic test_reset_misses();
        drive_lookup(6'd0, 10'h000);
        drain_lookups();
        drive_lookup(6'd17, 10'h155);
        drain_lookups();
        drive_lookup(6'd42, 10'h000);
        drain_lookups();
        drive_lookup(6'd63, 10'h3ff);
        drain_lookups();
        idle_for(10);  // Monitor flags any stray strobe
    endtask

    task automatic test_full_write_hit();
        drive_write(6'd5, 10'h2a5, 4'b1111, {$urandom, $urandom});
        drive_lookup(6'd5, 10'h2a5);
        drain_lookups();
    endtask

    task automatic test_partial_write_hit();
        drive_write(6'd30, 10'h0c3, 4'b1010, {$urandom, $urandom});
        drive_lookup(6'd30, 10'h0c3);
        drain_lookups();
    endtask

    task automatic test_tag_miss_and_replace();
        drive_write(6'd9, 10'h111, 4'b1111, {$urandom, $urandom});
        drive_lookup(6'd9, 10'h222);  // Same index, other tag
        drain_lookups();
        drive_write(6'd9, 10'h222, 4'b0101, {$urandom, $urandom});
        drive_lookup(6'd9, 10'h111);  // Old tag now gone
        drive_lookup(6'd9, 10'h222);
        drain_lookups();
    endtask

    task automatic test_random_stream();
        line_index_t idx;
        line_tag_t   tag;
        for (int i = 0; i < NUM_LINES; i++) begin
            drive_write(line_index_t'(i), line_tag_t'($urandom), col_mask_t'($urandom),
                        {$urandom, $urandom});
        end
        for (int i = 0; i < STREAM_LEN; i++) begin
            idx = line_index_t'($urandom_range(NUM_LINES - 1, 0));
            tag = ($urandom_range(3, 0) != 0) ? model_tag[idx] : line_tag_t'($urandom);  // Mostly hits
            drive_lookup(idx, tag);
        end
        drain_lookups();
    endtask

    // Watchdog
    initial begin
        #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        void'($urandom(32'hda01637f));
        rst_n    = 1'b0;
        wr_valid = 1'b0;
        wr_req   = '0;
        lu_valid = 1'b0;
        lu_req   = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            model_tag[i]   = '0;  // RAMs start cleared
            model_valid[i] = '0;
            model_data[i]  = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_misses();
        test_full_write_hit();
        test_partial_write_hit();
        test_tag_miss_and_replace();
        test_random_stream();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
